// File: files.f
logic/f100_pkg.sv
logic/exec_if.sv
logic/f100_execute.sv
logic/f100_sequencer.sv
logic/f100_top.sv
tb/f100_props.sv
tb/tb_f100.sv

// File: logic/exec_if.sv
/*
  Link between the sequencer and the execute unit.
  start is a one-cycle strobe; op and operand are only meaningful with it.
*/

`default_nettype none
`timescale 1ns/1ps

interface exec_if;

  // Strobe for an ALU operation
  logic start;

  f100_pkg::opcode_t op;
  f100_pkg::word_t   operand;

  // Current accumulator, used for STO data and ALU inputs
  f100_pkg::word_t   accum;

  modport sequencer
  (
    output start,
    output op,
    output operand,
    input  accum
  );

  modport execute
  (
    input  start,
    input  op,
    input  operand,
    output accum
  );

endinterface

`default_nettype wire

// File: logic/f100_execute.sv
/*
  ALU, accumulator and condition register of the core.
  Results are written on the edge that closes a start cycle.
  No multi-length carry-in: M, F and I flags are not implemented.
  CMP updates C S Z but keeps the accumulator and the V flag.
*/

`default_nettype none
`timescale 1ns/1ps

module f100_execute
(
  input  wire              raw_clk,
  input  wire              button_reset,
  exec_if.execute          ex,
  output f100_pkg::flags_t flags
);

  f100_pkg::word_t accum_q;

  // 17-bit result, bit 16 is the carry or borrow
  logic [16:0] result;
  logic        alu_op;
  logic        write_accum;
  logic        add_overflow;
  logic        sub_overflow;

  assign ex.accum = accum_q;

  always_comb
  begin
    result      = '0;
    alu_op      = 1'b0;
    write_accum = 1'b0;

    case (ex.op)
      f100_pkg::LDA:
      begin
        result      = {1'b0, ex.operand};
        alu_op      = 1'b1;
        write_accum = 1'b1;
      end
      f100_pkg::ADD:
      begin
        result      = {1'b0, ex.operand} + {1'b0, accum_q};
        alu_op      = 1'b1;
        write_accum = 1'b1;
      end
      f100_pkg::SUB:
      begin
        result      = {1'b0, ex.operand} - {1'b0, accum_q};
        alu_op      = 1'b1;
        write_accum = 1'b1;
      end
      f100_pkg::CMP:
      begin
        // Same subtraction as SUB, flags only
        result      = {1'b0, ex.operand} - {1'b0, accum_q};
        alu_op      = 1'b1;
      end
      f100_pkg::AND:
      begin
        result      = {1'b0, ex.operand & accum_q};
        alu_op      = 1'b1;
        write_accum = 1'b1;
      end
      f100_pkg::NEQ:
      begin
        result      = {1'b0, ex.operand ^ accum_q};
        alu_op      = 1'b1;
        write_accum = 1'b1;
      end
      default:
      begin
        result = '0;
      end
    endcase
  end

  // Signed overflow, operand is the left-hand side of the subtraction
  assign add_overflow = (accum_q[15] == ex.operand[15]) && (result[15] != accum_q[15]);
  assign sub_overflow = (accum_q[15] != ex.operand[15]) && (result[15] == accum_q[15]);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      accum_q <= '0;
      flags   <= '0;
    end
    else if (ex.start && alu_op)
    begin
      if (write_accum)
        accum_q <= result[15:0];

      flags[f100_pkg::FLAG_C] <= result[16];
      flags[f100_pkg::FLAG_S] <= result[15];
      flags[f100_pkg::FLAG_Z] <= (result[15:0] == '0);

      // V moves only on ADD and SUB
      if (ex.op == f100_pkg::ADD)
        flags[f100_pkg::FLAG_V] <= add_overflow;
      else if (ex.op == f100_pkg::SUB)
        flags[f100_pkg::FLAG_V] <= sub_overflow;
    end
  end

endmodule

`default_nettype wire

// File: logic/f100_pkg.sv
/*
  Shared types and constants for the cut-down F100-L core.
  Words are 16 bits. Only the short N and immediate ,D addressing modes exist.
  Opcodes outside the enum are treated as no-ops by the sequencer.
*/

`default_nettype none

package f100_pkg;

  // Data word, also used for addresses
  typedef logic [15:0] word_t;

  // Condition register, only C S V Z are kept
  typedef logic [3:0] flags_t;

  // Width of the short address field N in bits 10..0
  localparam int SHORT_ADDR_BITS = 11;

  typedef logic [SHORT_ADDR_BITS-1:0] short_addr_t;

  // Instruction bits 15..12
  typedef enum logic [3:0]
  {
    HALT = 4'h1,
    STO  = 4'h4,
    LDA  = 4'h8,
    ADD  = 4'h9,
    SUB  = 4'ha,
    CMP  = 4'hb,
    AND  = 4'hc,
    NEQ  = 4'hd,
    JMP  = 4'hf
  } opcode_t;

  // One instruction in flight at a time
  typedef enum logic [2:0]
  {
    FETCH   = 3'd0,
    DECODE  = 3'd1,
    OPERAND = 3'd2,
    EXECUTE = 3'd3,
    STORE   = 3'd4,
    HALTED  = 3'd5
  } seq_state_t;

  // Bit positions inside flags_t
  localparam int FLAG_C = 3;
  localparam int FLAG_S = 2;
  localparam int FLAG_V = 1;
  localparam int FLAG_Z = 0;

  // Start address picked by button_program_select
  localparam word_t BOOT_ADDR_RAM = 16'h0000;
  localparam word_t BOOT_ADDR_ROM = 16'h4000;

  // Bits 11..10 of the halt instruction
  localparam logic [1:0] HALT_SUBCODE = 2'b01;

endpackage

`default_nettype wire

// File: logic/f100_sequencer.sv
/*
  Instruction FSM, program counter and memory bus driver.
  Bus outputs decode the state, so read data must come back in the same cycle.
  One idle cycle follows reset before the first fetch at the boot address.
  button_halt is active low and taken as already synchronous to raw_clk.
*/

`default_nettype none
`timescale 1ns/1ps

module f100_sequencer
(
  input  wire                     raw_clk,
  input  wire                     button_reset,
  input  wire                     button_halt,
  input  wire                     button_program_select,
  output f100_pkg::word_t         mem_address,
  output f100_pkg::word_t         mem_write_data,
  output logic                    mem_enable,
  output logic                    mem_write,
  input  wire f100_pkg::word_t    mem_read_data,
  output logic                    halted,
  exec_if.sequencer               ex
);

  f100_pkg::seq_state_t state;

  f100_pkg::word_t pc;
  f100_pkg::word_t instr;
  f100_pkg::word_t ea;
  f100_pkg::word_t operand;

  f100_pkg::opcode_t     opcode;
  f100_pkg::short_addr_t short_addr;

  logic is_alu;
  logic mem_ref;
  logic is_halt;

  assign opcode     = f100_pkg::opcode_t'(instr[15:12]);
  assign short_addr = instr[f100_pkg::SHORT_ADDR_BITS-1:0];
  assign is_halt    = (opcode == f100_pkg::HALT) && (instr[11:10] == f100_pkg::HALT_SUBCODE);

  // Opcode classes
  always_comb
  begin
    is_alu  = 1'b0;
    mem_ref = 1'b0;

    case (opcode)
      f100_pkg::LDA, f100_pkg::ADD, f100_pkg::SUB,
      f100_pkg::CMP, f100_pkg::AND, f100_pkg::NEQ:
      begin
        is_alu  = 1'b1;
        mem_ref = 1'b1;
      end
      f100_pkg::STO, f100_pkg::JMP:
      begin
        mem_ref = 1'b1;
      end
      default:
      begin
        is_alu = 1'b0;
      end
    endcase
  end

  // Bus accesses happen in FETCH, OPERAND and STORE only
  assign mem_enable     = (state == f100_pkg::FETCH) ||
                          (state == f100_pkg::OPERAND) ||
                          (state == f100_pkg::STORE);
  assign mem_write      = (state == f100_pkg::STORE);
  assign mem_address    = (state == f100_pkg::FETCH) ? pc : ea;
  assign mem_write_data = ex.accum;

  assign halted = (state == f100_pkg::HALTED);

  assign ex.start   = (state == f100_pkg::EXECUTE) && is_alu;
  assign ex.op      = opcode;
  assign ex.operand = operand;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      // Park in EXECUTE with a null opcode so the bus stays quiet
      state <= f100_pkg::EXECUTE;
      instr <= '0;
      pc    <= button_program_select ? f100_pkg::BOOT_ADDR_ROM : f100_pkg::BOOT_ADDR_RAM;
    end
    else if (!button_halt)
    begin
      state <= f100_pkg::HALTED;
    end
    else
    begin
      case (state)
        f100_pkg::FETCH:
        begin
          instr <= mem_read_data;
          pc    <= pc + 16'd1;
          state <= f100_pkg::DECODE;
        end
        f100_pkg::DECODE:
        begin
          if (is_halt)
            state <= f100_pkg::HALTED;
          else if (!mem_ref)
            state <= f100_pkg::FETCH;
          else
          begin
            // N of zero means the operand word follows the instruction
            if (short_addr == '0)
              pc <= pc + 16'd1;

            if (opcode == f100_pkg::STO)
              state <= f100_pkg::STORE;
            else if (opcode == f100_pkg::JMP)
              state <= f100_pkg::EXECUTE;
            else
              state <= f100_pkg::OPERAND;
          end
        end
        f100_pkg::OPERAND:
        begin
          state <= f100_pkg::EXECUTE;
        end
        f100_pkg::EXECUTE:
        begin
          if (opcode == f100_pkg::JMP)
            pc <= ea;
          state <= f100_pkg::FETCH;
        end
        f100_pkg::STORE:
        begin
          state <= f100_pkg::FETCH;
        end
        f100_pkg::HALTED:
        begin
          state <= f100_pkg::HALTED;
        end
        default:
        begin
          state <= f100_pkg::HALTED;
        end
      endcase
    end
  end

  // Effective address and operand latch
  always_ff @(posedge raw_clk)
  begin
    if (state == f100_pkg::DECODE)
      ea <= (short_addr != '0) ? f100_pkg::word_t'(short_addr) : pc;

    if (state == f100_pkg::OPERAND)
      operand <= mem_read_data;
  end

endmodule

`default_nettype wire

// File: logic/f100_top.sv
/*
  Top level of the core with a plain single-cycle memory bus.
  Memory must answer reads combinationally while mem_enable is high.
  Writes are expected on the closing edge of a mem_enable and mem_write cycle.
*/

`default_nettype none
`timescale 1ns/1ps

module f100_top
(
  input  wire                   raw_clk,
  input  wire                   button_reset,
  input  wire                   button_halt,
  input  wire                   button_program_select,
  output wire f100_pkg::word_t  mem_address,
  output wire f100_pkg::word_t  mem_write_data,
  output wire                   mem_enable,
  output wire                   mem_write,
  input  wire f100_pkg::word_t  mem_read_data,
  output wire f100_pkg::word_t  accum,
  output wire f100_pkg::flags_t flags,
  output wire                   halted
);

  exec_if ex_bus();

  assign accum = ex_bus.accum;

  // Fetch, addressing and bus control
  f100_sequencer u_sequencer
  (
    .raw_clk               (raw_clk),
    .button_reset          (button_reset),
    .button_halt           (button_halt),
    .button_program_select (button_program_select),
    .mem_address           (mem_address),
    .mem_write_data        (mem_write_data),
    .mem_enable            (mem_enable),
    .mem_write             (mem_write),
    .mem_read_data         (mem_read_data),
    .halted                (halted),
    .ex                    (ex_bus.sequencer)
  );

  // ALU with accumulator and flags
  f100_execute u_execute
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .ex           (ex_bus.execute),
    .flags        (flags)
  );

endmodule

`default_nettype wire

// File: tb/f100_props.sv
/*
  Bus and halt protocol properties, bound into every f100_top.
  All properties are idle while button_reset is low.
*/

`default_nettype none
`timescale 1ns/1ps

module f100_props
(
  input wire                  raw_clk,
  input wire                  button_reset,
  input wire                  mem_enable,
  input wire                  mem_write,
  input wire f100_pkg::word_t mem_address,
  input wire                  halted
);

  // Number of property failures so far
  int unsigned fail_count = 0;

  // A write is always part of a bus access
  write_needs_enable: assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_write |-> mem_enable)
  else
  begin
    fail_count++;
    $error("mem_write is high while mem_enable is low");
  end

  // HALTED is a sink state with a silent bus
  halted_is_final: assert property (@(posedge raw_clk) disable iff (!button_reset)
    halted |=> (halted && !mem_enable))
  else
  begin
    fail_count++;
    $error("core left the halted state or touched the bus after halting");
  end

  known_address: assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_enable |-> !$isunknown(mem_address))
  else
  begin
    fail_count++;
    $error("mem_address is unknown during a bus access");
  end

endmodule

bind f100_top f100_props u_props
(
  .raw_clk      (raw_clk),
  .button_reset (button_reset),
  .mem_enable   (mem_enable),
  .mem_write    (mem_write),
  .mem_address  (mem_address),
  .halted       (halted)
);

`default_nettype wire

// File: tb/tb_f100.sv
/*
  Testbench for f100_top with a 64K-word memory model.
  Reads are answered combinationally and writes land on the rising edge.
  Programs start at a boot address and stop on the halt instruction or button.
*/

`default_nettype none
`timescale 1ns/1ps

module tb_f100;

  localparam int CLK_PERIOD      = 40;
  localparam int TEST_COUNT      = 15;
  localparam int CYCLES_PER_TEST = 200;
  localparam int TIMEOUT_CYCLES  = TEST_COUNT * CYCLES_PER_TEST;

  // Halt opcode with subcode 01
  localparam logic [15:0] HALT_WORD = 16'h1400;

  logic             raw_clk;
  logic             button_reset;
  logic             button_halt;
  logic             button_program_select;
  f100_pkg::word_t  mem_address;
  f100_pkg::word_t  mem_write_data;
  logic             mem_enable;
  logic             mem_write;
  f100_pkg::word_t  mem_read_data;
  f100_pkg::word_t  accum;
  f100_pkg::flags_t flags;
  logic             halted;

  f100_pkg::word_t mem [0:65535];

  int checks_run;
  int errors;
  int cycle_count;

  f100_top dut
  (
    .raw_clk               (raw_clk),
    .button_reset          (button_reset),
    .button_halt           (button_halt),
    .button_program_select (button_program_select),
    .mem_address           (mem_address),
    .mem_write_data        (mem_write_data),
    .mem_enable            (mem_enable),
    .mem_write             (mem_write),
    .mem_read_data         (mem_read_data),
    .accum                 (accum),
    .flags                 (flags),
    .halted                (halted)
  );

  assign mem_read_data = mem_enable ? mem[mem_address] : '0;

  always @(posedge raw_clk)
  begin
    if (mem_enable && mem_write)
      mem[mem_address] <= mem_write_data;
  end

  initial
  begin
    raw_clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) raw_clk = ~raw_clk;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge raw_clk);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // Background value that mixes every address bit
  function automatic f100_pkg::word_t fill_word(input int unsigned addr);
    return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
  endfunction

  task automatic check_word(input string test_name, input logic [15:0] expected,
                            input logic [15:0] actual);
    checks_run++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  // Reference result of LDA acc followed by op with opnd
  task automatic model_alu(input f100_pkg::opcode_t op, input logic [15:0] acc,
                           input logic [15:0] opnd, output logic [15:0] exp_accum,
                           output logic [3:0] exp_flags);
    int          wide;
    int          signed_res;
    logic [15:0] res;
    logic        carry;
    logic        ovf;
    wide       = 0;
    signed_res = 0;
    ovf        = 1'b0;
    carry      = 1'b0;
    case (op)
      f100_pkg::ADD:
      begin
        wide       = int'(opnd) + int'(acc);
        signed_res = int'($signed(opnd)) + int'($signed(acc));
        carry      = (wide > 65535);
        ovf        = (signed_res > 32767) || (signed_res < -32768);
        res        = wide[15:0];
      end
      f100_pkg::SUB, f100_pkg::CMP:
      begin
        wide       = int'(opnd) - int'(acc);
        signed_res = int'($signed(opnd)) - int'($signed(acc));
        carry      = (wide < 0);
        // CMP keeps the V flag that LDA left clear after reset
        if (op == f100_pkg::SUB)
          ovf = (signed_res > 32767) || (signed_res < -32768);
        res = wide[15:0];
      end
      f100_pkg::AND:
        res = opnd & acc;
      default:
        res = opnd ^ acc;
    endcase
    exp_accum = (op == f100_pkg::CMP) ? acc : res;
    exp_flags[f100_pkg::FLAG_C] = carry;
    exp_flags[f100_pkg::FLAG_S] = res[15];
    exp_flags[f100_pkg::FLAG_V] = ovf;
    exp_flags[f100_pkg::FLAG_Z] = (res == 16'h0000);
  endtask

  task automatic reset_core(input logic rom);
    @(posedge raw_clk);
    #1;
    button_reset          = 1'b0;
    button_halt           = 1'b1;
    button_program_select = rom;
    repeat (2) @(posedge raw_clk);
    #1;
    button_reset = 1'b1;
  endtask

  task automatic wait_halt(input string test_name);
    int waited;
    waited = 0;
    while (!halted && waited < CYCLES_PER_TEST)
    begin
      @(negedge raw_clk);
      waited++;
    end
    checks_run++;
    assert (halted)
    else
    begin
      errors++;
      $display("Test %s: core did not halt within %0d cycles", test_name, CYCLES_PER_TEST);
    end
  endtask

  initial
  begin
    f100_pkg::opcode_t alu_ops [5];
    f100_pkg::word_t   boot;
    logic [15:0]       value;
    logic [15:0]       op_a;
    logic [15:0]       op_b;
    logic [15:0]       exp_accum;
    logic [3:0]        exp_flags;
    string             name;
    int                waited;
    int                fetches;
    int                total_errors;

    void'($urandom(43));
    checks_run            = 0;
    errors                = 0;
    button_reset          = 1'b0;
    button_halt           = 1'b1;
    button_program_select = 1'b0;
    alu_ops = '{f100_pkg::ADD, f100_pkg::SUB, f100_pkg::CMP, f100_pkg::AND, f100_pkg::NEQ};
    for (int a = 0; a < 65536; a++)
      mem[a] <= fill_word(a);

    // Reset values and boot address for both select settings
    for (int sel = 0; sel < 2; sel++)
    begin
      boot = sel ? f100_pkg::BOOT_ADDR_ROM : f100_pkg::BOOT_ADDR_RAM;
      name = sel ? "reset_rom" : "reset_ram";
      // Program leaves accum and the S flag set before the next reset
      mem[boot]         <= 16'h8000;
      mem[boot + 16'd1] <= 16'h8000;
      mem[boot + 16'd2] <= HALT_WORD;
      reset_core(sel[0]);
      @(negedge raw_clk);
      check_word(name, 16'h0000, {13'd0, halted, mem_enable, mem_write});
      check_word(name, 16'h0000, accum);
      check_word(name, 16'h0000, {12'd0, flags});
      waited = 0;
      while (!mem_enable && waited < CYCLES_PER_TEST)
      begin
        @(negedge raw_clk);
        waited++;
      end
      check_word(name, boot, mem_address);
      check_word(name, 16'h0000, 16'(mem_write));
      wait_halt(name);
    end

    // LDA ,D then STO 0x123
    value = 16'($urandom());
    mem[16'h0000] <= 16'h8000;
    mem[16'h0001] <= value;
    mem[16'h0002] <= 16'h4123;
    mem[16'h0003] <= HALT_WORD;
    reset_core(1'b0);
    wait_halt("load_store");
    check_word("load_store", value, mem[16'h0123]);
    check_word("load_store", value, accum);

    for (int round = 0; round < 2; round++)
    begin
      for (int i = 0; i < 5; i++)
      begin
        op_a = 16'($urandom());
        op_b = 16'($urandom());
        name = $sformatf("alu_%s", alu_ops[i].name());
        mem[16'h4000] <= 16'h8000;
        mem[16'h4001] <= op_a;
        mem[16'h4002] <= {alu_ops[i], 12'h000};
        mem[16'h4003] <= op_b;
        mem[16'h4004] <= HALT_WORD;
        reset_core(1'b1);
        wait_halt(name);
        model_alu(alu_ops[i], op_a, op_b, exp_accum, exp_flags);
        check_word(name, exp_accum, accum);
        check_word(name, {12'd0, exp_flags}, {12'd0, flags});
      end
    end

    // JMP 0x040 jumps over STO 0x140
    value = 16'($urandom());
    mem[16'h0000] <= 16'h8000;
    mem[16'h0001] <= value;
    mem[16'h0002] <= 16'hf040;
    mem[16'h0003] <= 16'h4140;
    mem[16'h0004] <= HALT_WORD;
    mem[16'h0040] <= HALT_WORD;
    reset_core(1'b0);
    wait_halt("jump");
    check_word("jump", fill_word(16'h0140), mem[16'h0140]);
    check_word("jump", value, accum);

    // Tight JMP loop stopped by the halt button
    mem[16'h0000] <= 16'h8000;
    mem[16'h0001] <= value;
    mem[16'h0002] <= 16'hf002;
    reset_core(1'b0);
    fetches = 0;
    waited  = 0;
    while (fetches < 4 && waited < CYCLES_PER_TEST)
    begin
      @(negedge raw_clk);
      waited++;
      if (mem_enable && !mem_write && mem_address == 16'h0002)
        fetches++;
    end
    // The loop must still be running when the button is pressed
    check_word("button_halt", 16'd4, 16'(fetches));
    @(posedge raw_clk);
    #1;
    button_halt = 1'b0;
    wait_halt("button_halt");
    repeat (8)
    begin
      @(negedge raw_clk);
      check_word("button_halt", 16'h0004, {13'd0, halted, mem_enable, mem_write});
    end
    check_word("button_halt", value, accum);

    total_errors = errors + int'(dut.u_props.fail_count);
    $display("Checks run: %0d, errors: %0d, property failures: %0d",
             checks_run, errors, dut.u_props.fail_count);
    if (total_errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
